// ==== common/charz_pkg.sv ====
package charz_pkg;

    // campaign timing
    localparam int RESET_THRESHOLD = 64;
    localparam int NUMBER_OF_RUNS  = 40;
    localparam int GAP_CYCLES      = 10;

    // histogram geometry
    // bin 0 holds the completion marker, durations start at 1
    localparam int NUM_BINS = 64;
    localparam int BIN_W    = 6;
    localparam int ADDR_W   = 8;

    localparam logic [31:0] DONE_MARKER = 32'hffff_ffff;

    // counter widths derived from the limits above
    // the start-up counter is reused for the gap between rounds
    localparam int WAIT_W    = $clog2(RESET_THRESHOLD + 1);
    localparam int RUN_CNT_W = $clog2(NUMBER_OF_RUNS + 1);

    typedef logic [BIN_W-1:0] duration_t;

    // meter to controller
    typedef struct packed {
        logic      valid;
        duration_t duration;
    } meas_result_t;

    // controller to RAM port A
    typedef struct packed {
        logic [3:0]        we;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
    } mem_req_t;

    // round sequencing
    typedef enum logic [1:0] {
        ST_WAIT_START,
        ST_RUNNING,
        ST_GAP,
        ST_DONE
    } run_state_t;

    // histogram update sequencing
    typedef enum logic [2:0] {
        MS_IDLE,
        MS_READ,
        MS_WRITE,
        MS_MARK,
        MS_FINISHED
    } mem_state_t;

endpackage

// ==== source/duration_meter.sv ====
module duration_meter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    round_start,
    input  logic                    device_done,
    output charz_pkg::meas_result_t result
);
    import charz_pkg::*;

    logic      running;
    logic      valid_q;
    duration_t count;
    duration_t count_next;
    duration_t duration_q;

    // long rounds pile up in the last bin
    assign count_next = (count == duration_t'(NUM_BINS - 1)) ? count : count + 1'b1;

    // round tracking and result valid
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            valid_q <= 1'b0;
        end else if (round_start) begin
            running <= 1'b1;
            valid_q <= 1'b0;
        end else if (running && device_done) begin
            running <= 1'b0;
            valid_q <= 1'b1;
        end
    end

    // the edge that samples round_start is the first counted edge
    always_ff @(posedge clk) begin
        if (round_start) begin
            count <= duration_t'(1);
        end else if (running) begin
            count <= count_next;
            // done edge is counted too
            if (device_done) begin
                duration_q <= count_next;
            end
        end
    end

    // held until the next round_start
    assign result = '{valid: valid_q, duration: duration_q};

    // done only answers a round that was already started
    a_done_in_round: assert property (
        @(posedge clk) disable iff (reset)
        device_done |-> running && !round_start
    );

endmodule

// ==== round_control/round_controller.sv ====
module round_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    device_busy,
    input  charz_pkg::meas_result_t result,
    input  logic [31:0]             rdata,
    output logic                    round_start,
    output charz_pkg::mem_req_t     mem_req
);
    import charz_pkg::*;

    run_state_t           run_state;
    mem_state_t           mem_state;
    logic [WAIT_W-1:0]    wait_count;
    logic [RUN_CNT_W-1:0] round_count;
    logic                 valid_d;
    logic                 valid_rise;
    logic [31:0]          old_val;
    logic [ADDR_W-1:0]    bin_addr;

    // a new result shows up as a rising edge on valid
    assign valid_rise = result.valid && !valid_d;

    // word address of the bin, byte addressed
    assign bin_addr = {result.duration, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            run_state   <= ST_WAIT_START;
            wait_count  <= '0;
            round_start <= 1'b0;
            valid_d     <= 1'b0;
        end else begin
            valid_d     <= result.valid;
            round_start <= 1'b0;
            case (run_state)
                ST_WAIT_START: begin
                    // start-up wait, then hold off while the device is busy
                    if (wait_count < WAIT_W'(RESET_THRESHOLD)) begin
                        wait_count <= wait_count + 1'b1;
                    end else if (!device_busy) begin
                        run_state   <= ST_RUNNING;
                        round_start <= 1'b1;
                    end
                end
                ST_RUNNING: begin
                    wait_count <= '0;
                    if (valid_rise) begin
                        if (round_count < RUN_CNT_W'(NUMBER_OF_RUNS)) begin
                            run_state <= ST_GAP;
                        end else begin
                            run_state <= ST_DONE;
                        end
                    end
                end
                ST_GAP: begin
                    if (wait_count >= WAIT_W'(GAP_CYCLES)) begin
                        run_state   <= ST_RUNNING;
                        round_start <= 1'b1;
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end
                ST_DONE: begin
                    // campaign over, stay here
                    run_state <= ST_DONE;
                end
                default: begin
                    run_state <= ST_WAIT_START;
                end
            endcase
        end
    end

    // rounds started so far
    always_ff @(posedge clk) begin
        if (reset) begin
            round_count <= '0;
        end else if (round_start) begin
            round_count <= round_count + 1'b1;
        end
    end

    // read, latch, write back, then the marker after the last round
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_state <= MS_IDLE;
        end else begin
            case (mem_state)
                MS_IDLE: begin
                    if (valid_rise && run_state == ST_RUNNING) begin
                        mem_state <= MS_READ;
                    end
                end
                MS_READ: begin
                    mem_state <= MS_WRITE;
                end
                MS_WRITE: begin
                    if (run_state == ST_DONE) begin
                        mem_state <= MS_MARK;
                    end else begin
                        mem_state <= MS_IDLE;
                    end
                end
                MS_MARK: begin
                    mem_state <= MS_FINISHED;
                end
                default: begin
                    mem_state <= MS_FINISHED;
                end
            endcase
        end
    end

    // old bin count
    always_ff @(posedge clk) begin
        if (mem_state == MS_READ) begin
            old_val <= rdata;
        end
    end

    // idle presents the bin address, which is the read
    always_comb begin
        mem_req = '{we: 4'b0000, addr: bin_addr, wdata: '0};
        case (mem_state)
            MS_WRITE: begin
                mem_req.we    = 4'b1111;
                mem_req.wdata = old_val + 32'd1;
            end
            MS_MARK: begin
                mem_req.we    = 4'b1111;
                mem_req.addr  = '0;
                mem_req.wdata = DONE_MARKER;
            end
            default: begin
            end
        endcase
    end

    a_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        round_start |=> !round_start
    );

    // word 0 belongs to the marker, written only once the campaign is over
    a_no_early_marker: assert property (
        @(posedge clk) disable iff (reset)
        (|mem_req.we && mem_req.addr == '0) |-> run_state == ST_DONE
    );

endmodule

// ==== source/histogram_ram.sv ====
module histogram_ram (
    input  logic                         clk,
    input  charz_pkg::mem_req_t          mem_req,
    output logic [31:0]                  rdata_a,
    input  logic [charz_pkg::ADDR_W-1:0] host_addr,
    output logic [31:0]                  host_rdata
);
    import charz_pkg::*;

    // starts cleared at configuration
    logic [31:0] mem [NUM_BINS] = '{default: 32'h0};

    logic [ADDR_W-3:0] word_a;
    logic [ADDR_W-3:0] word_b;

    // byte address to word index
    assign word_a = mem_req.addr[ADDR_W-1:2];
    assign word_b = host_addr[ADDR_W-1:2];

    // port A does byte masked writes and a registered read
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (mem_req.we[b]) begin
                mem[word_a][8*b +: 8] <= mem_req.wdata[8*b +: 8];
            end
        end
        rdata_a <= mem[word_a];
    end

    // port B is the read-only host side
    always_ff @(posedge clk) begin
        host_rdata <= mem[word_b];
    end

endmodule

// ==== source/charz_top.sv ====
module charz_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         device_busy,
    input  logic                         device_done,
    output logic                         round_start,
    input  logic [charz_pkg::ADDR_W-1:0] host_addr,
    output logic [31:0]                  host_rdata
);
    import charz_pkg::*;

    meas_result_t result;
    mem_req_t     mem_req;
    logic [31:0]  rdata_a;

    // turns done into a held duration
    duration_meter u_meter (
        .clk         (clk),
        .reset       (reset),
        .round_start (round_start),
        .device_done (device_done),
        .result      (result)
    );

    // rounds and histogram updates
    round_controller u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .device_busy (device_busy),
        .result      (result),
        .rdata       (rdata_a),
        .round_start (round_start),
        .mem_req     (mem_req)
    );

    // port B goes straight to the host
    histogram_ram u_ram (
        .clk        (clk),
        .mem_req    (mem_req),
        .rdata_a    (rdata_a),
        .host_addr  (host_addr),
        .host_rdata (host_rdata)
    );

endmodule

// ==== tb/charz_model.svh ====
`ifndef CHARZ_MODEL_SVH
`define CHARZ_MODEL_SVH

// one step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// histogram bin for a device delay
// the edge that takes round_start and the edge that takes done both count,
// so a delay of d cycles gives d+1, capped at the last bin
function automatic int unsigned duration_of(input int unsigned delay);
    int unsigned edges;
    edges = delay + 1;
    if (edges > NUM_BINS - 1) begin
        return NUM_BINS - 1;
    end
    return edges;
endfunction

// expected content of one histogram word from the recorded delays
function automatic logic [31:0] reference_bin(input int bin);
    logic [31:0] hits;
    hits = '0;
    foreach (delay_q[i]) begin
        if (duration_of(delay_q[i]) == bin) begin
            hits = hits + 32'd1;
        end
    end
    return hits;
endfunction

// RAM word compare
task automatic check_word(
    input logic [31:0] got,
    input logic [31:0] expected,
    input string       what
);
    if (got !== expected) begin
        report_mismatch($sformatf("%s: got %h, expected %h", what, got, expected));
    end
endtask

// round and pulse count compare
task automatic check_count(
    input int    got,
    input int    expected,
    input string what
);
    if (got != expected) begin
        report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, expected));
    end
endtask

`endif

// ==== tb/tb_charz.sv ====
module tb_charz;
    timeunit 1ns;
    timeprecision 100ps;

    import charz_pkg::*;

    localparam int BUSY_CYCLES    = 100;
    localparam int MAX_DELAY      = 80;
    localparam int START_TIMEOUT  = 1000;
    localparam int MARKER_TIMEOUT = 20000;

    logic              clk = 1'b0;
    logic              reset;
    logic              device_busy;
    logic              device_done;
    logic              round_start;
    logic [ADDR_W-1:0] host_addr;
    logic [31:0]       host_rdata;

    logic [31:0]       rng_state = 32'hd06d;
    int unsigned       delay_q[$];
    int                done_count = 0;
    int                pulse_count = 0;
    int                cycles_out_of_reset = 0;
    int                fail_count = 0;
    logic              marker_seen = 1'b0;
    logic              start_d = 1'b0;

    `include "charz_model.svh"

    charz_top UUT (
        .clk         (clk),
        .reset       (reset),
        .device_busy (device_busy),
        .device_done (device_done),
        .round_start (round_start),
        .host_addr   (host_addr),
        .host_rdata  (host_rdata)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        fail_count++;
        $display("[FAIL] %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no %s arrived within the time limit", what);
        stop_with_failure();
    endtask

    function automatic int unsigned next_delay();
        rng_state = xorshift32(rng_state);
        return 1 + (rng_state % MAX_DELAY);
    endfunction

    task automatic wait_round_start();
        int cycles;
        cycles = 0;
        while (round_start !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > START_TIMEOUT) begin
                report_timeout("round_start pulse");
            end
        end
    endtask

    // device model answers each round with a random delay once busy drops
    task automatic run_device();
        int unsigned delay;
        repeat (BUSY_CYCLES) @(posedge clk);
        #1;
        device_busy = 1'b0;
        for (int r = 0; r < NUMBER_OF_RUNS; r++) begin
            wait_round_start();
            delay = next_delay();
            delay_q.push_back(delay);
            repeat (delay) @(posedge clk);
            #1;
            device_done = 1'b1;
            done_count++;
            @(posedge clk);
            #1;
            device_done = 1'b0;
        end
    endtask

    task automatic host_read(input int bin, output logic [31:0] data);
        @(posedge clk);
        #1;
        host_addr = ADDR_W'(bin * 4);
        @(posedge clk);
        @(negedge clk);
        data = host_rdata;
    endtask

    // watches round_start at mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            if (round_start !== 1'b0) begin
                report_mismatch("round_start high during reset");
            end
        end else begin
            cycles_out_of_reset++;
            if (round_start === 1'b1) begin
                if (cycles_out_of_reset <= RESET_THRESHOLD) begin
                    report_mismatch("round_start inside the start-up wait");
                end
                if (device_busy) begin
                    report_mismatch("round_start while the device is busy");
                end
                if (start_d) begin
                    report_mismatch("round_start longer than one cycle");
                end
                if (marker_seen) begin
                    report_mismatch("round_start after the completion marker");
                end
                pulse_count++;
            end
            start_d = round_start;
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] hist [NUM_BINS];
        int          total;
        int          wait_cycles;
        reset       = 1'b1;
        device_busy = 1'b1;
        device_done = 1'b0;
        host_addr   = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            run_device();
        join_none

        // host polls word 0 for the whole campaign
        wait_cycles = 0;
        while (host_rdata !== DONE_MARKER) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > MARKER_TIMEOUT) begin
                report_timeout("completion marker in word 0");
            end
        end
        check_count(done_count, NUMBER_OF_RUNS, "device done pulses before the marker");

        // read latency on the marker word
        @(posedge clk);
        #1;
        marker_seen = 1'b1;
        host_addr   = ADDR_W'(4);
        @(posedge clk);
        #1;
        host_addr = '0;
        @(negedge clk);
        check_word(host_rdata, reference_bin(1), "host data in the address cycle");
        @(negedge clk);
        check_word(host_rdata, DONE_MARKER, "host data one cycle after the address");

        // quiet period lets the watcher catch a late pulse
        repeat (4 * GAP_CYCLES) @(posedge clk);
        check_count(pulse_count, NUMBER_OF_RUNS, "round_start pulses");

        // whole histogram first, so the sum is judged on its own
        total = 0;
        for (int b = 1; b < NUM_BINS; b++) begin
            host_read(b, word);
            hist[b] = word;
            total += int'(word);
        end
        check_count(total, NUMBER_OF_RUNS, "sum of histogram bins");

        for (int b = 1; b < NUM_BINS; b++) begin
            check_word(hist[b], reference_bin(b), $sformatf("histogram bin %0d", b));
        end

        if (fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// ==== flist.f ====
+incdir+tb
common/charz_pkg.sv
source/duration_meter.sv
round_control/round_controller.sv
source/histogram_ram.sv
source/charz_top.sv
tb/tb_charz.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_charz \
    --Mdir obj_dir -o sim_charz \
    -f flist.f

./obj_dir/sim_charz | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi
